// ==== fifo16_pkg.sv ====
/*
 * FIFO16 shared definitions.
 * Sizes and word types for the 16-entry, 8-bit synchronous FIFO.
 */
package fifo16_pkg;

        // Storage geometry.
        localparam int depth  = 16;             // Number of data words.
        localparam int addr_w = 4;              // Storage address width.

        // One extra bit on each pointer tells a full FIFO from an empty one.
        localparam int ptr_w  = addr_w + 1;

        // Payload width.
        localparam int data_w = 8;              // One byte per entry.

        // Data word as stored and as seen on do_m.
        typedef logic [data_w-1:0] data_t;

        // Index into the register array.
        typedef logic [addr_w-1:0] addr_t;

        // Read and write pointers.
        // The MSB is the wrap bit, the low bits address the array.
        typedef logic [ptr_w-1:0]  ptr_t;

        // Fill level, 0 up to depth.
        // Same width as a pointer so that 16 fits.
        typedef logic [ptr_w-1:0]  level_t;

endpackage

// ==== fifo16_mem_if.sv ====
/*
 * FIFO16 storage interface.
 * Write port from the write controller, read port from the read
 * controller, both served by the register array.
 */
`timescale 1ns/100ps

interface fifo16_mem_if;

        // Write side.
        fifo16_pkg::addr_t aw;                  // Write address.
        fifo16_pkg::data_t d;                   // Write data.
        logic              we;                  // Accepted write, full already checked.

        // Read side.
        fifo16_pkg::addr_t ar;                  // Read address, head of FIFO.
        fifo16_pkg::data_t q;                   // Word at ar, unregistered.

        // Write controller.
        modport wr
        (
                output aw,
                output d,
                output we
        );

        // Read controller.
        modport rd
        (
                output ar,
                input  q
        );

        // Register array.
        modport mem
        (
                input  aw,
                input  d,
                input  we,
                input  ar,
                output q
        );

endinterface

// ==== fifo16_regs.sv ====
/*
 * FIFO16 register array.
 * Sixteen data words with one clocked write port and one
 * combinational read port for first-word fall-through.
 */
`timescale 1ns/100ps

module fifo16_regs
(
        input  logic      clk,
        fifo16_mem_if.mem mem
);

        // The data words themselves.
        fifo16_pkg::data_t words [fifo16_pkg::depth];

        // One-hot word select for the write port.
        logic [fifo16_pkg::depth-1:0] wr_sel;

        // Address decode.
        // we is only high for accepted writes, so no full test here.
        always_comb
        begin
                wr_sel         = '0;
                wr_sel[mem.aw] = mem.we;
        end

        // One load enable per word.
        for (genvar g = 0; g < fifo16_pkg::depth; g++)
        begin : g_word
                always_ff @(posedge clk)
                begin
                        if (wr_sel[g])
                        begin
                                words[g] <= mem.d;      // Capture on the write edge.
                        end
                end
        end

        // Read mux.
        // Head word goes straight out, no output register.
        always_comb
        begin
                mem.q = words[mem.ar];
        end

endmodule

// ==== fifo16_wr_ctrl.sv ====
/*
 * FIFO16 write controller.
 * Keeps the write pointer, derives full and issues accepted writes
 * to the register array.
 */
`timescale 1ns/100ps

module fifo16_wr_ctrl
(
        input  logic              clk,
        input  logic              arst_n,
        input  logic              wr_n,         // Write strobe, active low.
        input  fifo16_pkg::data_t d,            // Word to store.
        input  fifo16_pkg::ptr_t  rd_ptr,       // From the read controller.
        output fifo16_pkg::ptr_t  wr_ptr,       // To the read controller.
        output logic              full,
        fifo16_mem_if.wr          mem
);

        logic             wr_accept;            // Strobe seen and room left.
        logic             wrap_diff;            // Pointers on different laps.
        logic             addr_same;            // Same array slot.
        fifo16_pkg::ptr_t wr_ptr_nxt;

        // Full when the write pointer is one whole lap ahead.
        // Compare the wrap bit and the slot address separately.
        always_comb
        begin
                wrap_diff = wr_ptr[fifo16_pkg::addr_w] != rd_ptr[fifo16_pkg::addr_w];
                addr_same = wr_ptr[fifo16_pkg::addr_w-1:0] == rd_ptr[fifo16_pkg::addr_w-1:0];
                full      = wrap_diff && addr_same;
        end

        // A strobe while full is simply lost.
        always_comb
        begin
                wr_accept = !wr_n && !full;
        end

        // Next slot; the wrap bit toggles after slot 15.
        always_comb
        begin
                wr_ptr_nxt = wr_ptr + fifo16_pkg::ptr_t'(1);
        end

        // Write pointer.
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        wr_ptr <= '0;                   // Start at slot 0, lap 0.
                end
                else if (wr_accept)
                begin
                        wr_ptr <= wr_ptr_nxt;
                end
        end

        // Drive the array's write port.
        always_comb
        begin
                mem.we = wr_accept;                     // Gated write enable.
                mem.d  = d;                             // Data passes through.
                mem.aw = wr_ptr[fifo16_pkg::addr_w-1:0];
        end

endmodule

// ==== fifo16_rd_ctrl.sv ====
/*
 * FIFO16 read controller.
 * Keeps the read pointer, derives empty and the fill level and
 * presents the head word on do_m.
 */
`timescale 1ns/100ps

module fifo16_rd_ctrl
(
        input  logic               clk,
        input  logic               arst_n,
        input  logic               rd_n,        // Read strobe, active low.
        input  fifo16_pkg::ptr_t   wr_ptr,      // From the write controller.
        output fifo16_pkg::ptr_t   rd_ptr,      // To the write controller.
        output logic               empty,
        output fifo16_pkg::level_t level,       // Words held, 0 to 16.
        output fifo16_pkg::data_t  do_m,        // Head word.
        fifo16_mem_if.rd           mem
);

        logic             rd_accept;            // Strobe seen and data present.
        fifo16_pkg::ptr_t rd_ptr_nxt;

        // Empty when both pointers match, wrap bit included.
        always_comb
        begin
                empty = (wr_ptr == rd_ptr);
        end

        // Modulo-32 difference of the pointers gives 0 to 16 directly.
        always_comb
        begin
                level = fifo16_pkg::level_t'(wr_ptr - rd_ptr);
        end

        // A read strobe while empty does nothing.
        always_comb
        begin
                rd_accept = !rd_n && !empty;
        end

        always_comb
        begin
                rd_ptr_nxt = rd_ptr + fifo16_pkg::ptr_t'(1);
        end

        // Read pointer.
        // Moves past the word consumed in this cycle.
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        rd_ptr <= '0;
                end
                else if (rd_accept)
                begin
                        rd_ptr <= rd_ptr_nxt;
                end
        end

        // Head of FIFO.
        // The array is addressed by the current pointer, so do_m
        // shows the next word right after each accepted read.
        always_comb
        begin
                mem.ar = rd_ptr[fifo16_pkg::addr_w-1:0];
                do_m   = mem.q;                 // Fall-through, no register.
        end

endmodule

// ==== fifo16_top.sv ====
/*
 * FIFO16 top level.
 * 16 x 8 synchronous FIFO with active-low strobes, first-word
 * fall-through output, full, empty and fill level.
 */
`timescale 1ns/100ps

module fifo16_top
(
        input  logic               clk,
        input  logic               arst_n,      // Async reset, active low.
        input  logic               wr_n,        // Write strobe.
        input  logic               rd_n,        // Read strobe.
        input  fifo16_pkg::data_t  d,           // Write data.
        output fifo16_pkg::data_t  do_m,        // Head word, valid when not empty.
        output logic               full,
        output logic               empty,
        output fifo16_pkg::level_t level
);

        // Pointers swapped between the two controllers.
        fifo16_pkg::ptr_t wr_ptr;
        fifo16_pkg::ptr_t rd_ptr;

        // Storage port bundle.
        fifo16_mem_if i_mem_if ();

        // Write side.
        // Owns full and the write enable.
        fifo16_wr_ctrl i_wr_ctrl
        (
                .clk    (clk),
                .arst_n (arst_n),
                .wr_n   (wr_n),
                .d      (d),
                .rd_ptr (rd_ptr),
                .wr_ptr (wr_ptr),
                .full   (full),
                .mem    (i_mem_if.wr)
        );

        // Read side.
        // Owns empty, level and do_m.
        fifo16_rd_ctrl i_rd_ctrl
        (
                .clk    (clk),
                .arst_n (arst_n),
                .rd_n   (rd_n),
                .wr_ptr (wr_ptr),
                .rd_ptr (rd_ptr),
                .empty  (empty),
                .level  (level),
                .do_m   (do_m),
                .mem    (i_mem_if.rd)
        );

        // Data words.
        fifo16_regs i_regs
        (
                .clk (clk),
                .mem (i_mem_if.mem)
        );

endmodule

// ==== fifo16_asserts.sv ====
/*
 * FIFO16 assertions.
 * Flag, level and pointer rules, bound into the top level.
 */
`timescale 1ns/100ps

module fifo16_asserts
(
        input logic               clk,
        input logic               arst_n,
        input logic               wr_n,
        input logic               rd_n,
        input logic               full,
        input logic               empty,
        input fifo16_pkg::level_t level,
        input fifo16_pkg::ptr_t   wr_ptr,
        input fifo16_pkg::ptr_t   rd_ptr
);

        // Flags exclude each other.
        a_flags_apart: assert property (@(posedge clk) disable iff (!arst_n) !(full && empty))
                else $error("full and empty are high together");

        a_level_max: assert property (@(posedge clk) disable iff (!arst_n)
                level <= fifo16_pkg::level_t'(fifo16_pkg::depth))
                else $error("level is above the FIFO depth");

        // A stored word clears empty on the next cycle.
        a_wr_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
                (!wr_n && !full) |=> !empty)
                else $error("empty still high after an accepted write");

        // Refused strobes leave the pointers alone.
        a_wr_ptr_hold: assert property (@(posedge clk) disable iff (!arst_n)
                (wr_n || full) |=> $stable(wr_ptr))
                else $error("write pointer moved without an accepted write");

        a_rd_ptr_hold: assert property (@(posedge clk) disable iff (!arst_n)
                (rd_n || empty) |=> $stable(rd_ptr))
                else $error("read pointer moved without an accepted read");

endmodule

bind fifo16_top fifo16_asserts i_asserts
(
        .clk    (clk),
        .arst_n (arst_n),
        .wr_n   (wr_n),
        .rd_n   (rd_n),
        .full   (full),
        .empty  (empty),
        .level  (level),
        .wr_ptr (wr_ptr),
        .rd_ptr (rd_ptr)
);

// ==== fifo16_tb.sv ====
/*
 * FIFO16 testbench.
 * Drives the strobes, keeps a queue model of the FIFO and compares
 * do_m, full, empty and level just before every rising edge.
 */
`timescale 1ns/100ps

module fifo16_tb;

        // Expected outputs, as derived from the queue model.
        typedef struct packed
        {
                fifo16_pkg::data_t  head;
                logic               full;
                logic               empty;
                fifo16_pkg::level_t level;
        } expect_t;

        logic               clk;
        logic               arst_n;
        logic               wr_n;
        logic               rd_n;
        fifo16_pkg::data_t  d;
        fifo16_pkg::data_t  do_m;
        logic               full;
        logic               empty;
        fifo16_pkg::level_t level;

        fifo16_pkg::data_t  model_q [$];        // Words held, head first.
        int                 value_errs = 0;     // Output mismatches.
        int                 timeouts   = 0;     // Waits that ran out.

        fifo16_top i_dut
        (
                .clk    (clk),
                .arst_n (arst_n),
                .wr_n   (wr_n),
                .rd_n   (rd_n),
                .d      (d),
                .do_m   (do_m),
                .full   (full),
                .empty  (empty),
                .level  (level)
        );

        // 8 ns clock.
        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Expected head, flags and level from the queue contents.
        function automatic expect_t fifo_expect();
                expect_t e;
                e.level = fifo16_pkg::level_t'(model_q.size());
                e.empty = (model_q.size() == 0);
                e.full  = (model_q.size() == fifo16_pkg::depth);
                e.head  = e.empty ? '0 : model_q[0];   // Head undefined when empty.
                return e;
        endfunction

        // Compare just before each edge, then apply the strobes of this cycle.
        initial
        begin : compare
                expect_t exp;
                logic    wr_ok;
                logic    rd_ok;
                forever
                begin
                        @(posedge clk);
                        #7;
                        if (arst_n)
                        begin
                                exp = fifo_expect();
                                assert (full === exp.full)
                                else
                                begin
                                        value_errs++;
                                        $display("ERR %0t: full is %b, expected %b",
                                                 $time, full, exp.full);
                                end
                                assert (empty === exp.empty)
                                else
                                begin
                                        value_errs++;
                                        $display("ERR %0t: empty is %b, expected %b",
                                                 $time, empty, exp.empty);
                                end
                                assert (level === exp.level)
                                else
                                begin
                                        value_errs++;
                                        $display("ERR %0t: level is %0d, expected %0d",
                                                 $time, level, exp.level);
                                end
                                assert (exp.empty || do_m === exp.head)
                                else
                                begin
                                        value_errs++;
                                        $display("ERR %0t: do_m is %h, expected %h",
                                                 $time, do_m, exp.head);
                                end
                                wr_ok = !wr_n && !exp.full;     // Write refused when full.
                                rd_ok = !rd_n && !exp.empty;    // Read ignored when empty.
                                if (rd_ok)
                                        void'(model_q.pop_front());
                                if (wr_ok)
                                        model_q.push_back(d);
                        end
                end
        end

        // One cycle of strobes, 1 ns after the edge.
        task automatic drive_cycle(input logic wr, input logic rd, input fifo16_pkg::data_t data);
                @(posedge clk);
                #1;
                wr_n = wr;
                rd_n = rd;
                d    = data;
        endtask

        // Idle until full reaches the wanted value.
        task automatic wait_full(input logic want, input int limit);
                int n;
                n = 0;
                while (full !== want && n < limit)
                begin
                        drive_cycle(1'b1, 1'b1, 8'h00);
                        n++;
                end
                if (full !== want)
                begin
                        timeouts++;
                        $display("Timeout: full did not become %b within %0d cycles", want, limit);
                end
        endtask

        // Write random words until full rises.
        task automatic fill_until_full(input int limit);
                int n;
                n = 0;
                while (!full && n < limit)
                begin
                        drive_cycle(1'b0, 1'b1, fifo16_pkg::data_t'($urandom));
                        n++;
                end
                drive_cycle(1'b1, 1'b1, 8'h00);
                if (!full)
                begin
                        timeouts++;
                        $display("Timeout: the FIFO did not fill within %0d cycles", limit);
                end
        endtask

        // Read until empty rises; the checker compares every word.
        task automatic drain_until_empty(input int limit);
                int n;
                n = 0;
                while (!empty && n < limit)
                begin
                        drive_cycle(1'b1, 1'b0, 8'h00);
                        n++;
                end
                drive_cycle(1'b1, 1'b1, 8'h00);
                if (!empty)
                begin
                        timeouts++;
                        $display("Timeout: the FIFO did not drain within %0d cycles", limit);
                end
        endtask

        initial
        begin : stimulus
                int wr_pct;
                int rd_pct;
                void'($urandom(47254));         // Seed once.
                arst_n   = 1'b0;
                wr_n     = 1'b1;
                rd_n     = 1'b1;
                d        = '0;
                repeat (16) @(posedge clk);
                #1;
                arst_n = 1'b1;

                // 1. State after reset.
                @(negedge clk);
                assert (empty === 1'b1 && full === 1'b0 && level === '0)
                else
                begin
                        value_errs++;
                        $display("ERR %0t: flags after reset e=%b f=%b l=%0d",
                                 $time, empty, full, level);
                end

                // 2. Sixteen writes, one dropped write, then sixteen reads in order.
                for (int i = 0; i < fifo16_pkg::depth; i++)
                        drive_cycle(1'b0, 1'b1, fifo16_pkg::data_t'(8'h10 + i));
                wait_full(1'b1, 4);
                drive_cycle(1'b0, 1'b1, 8'hee);         // Lost, FIFO is full.
                drain_until_empty(24);

                // 3. Reads while empty.
                repeat (4) drive_cycle(1'b1, 1'b0, 8'h33);
                drive_cycle(1'b1, 1'b1, 8'h00);

                // 4. Random mixes, biased to reach full, then empty, then even.
                for (int i = 0; i < 2000; i++)
                begin
                        wr_pct = (i < 500) ? 70 : (i < 1000) ? 30 : 50;
                        rd_pct = 100 - wr_pct;
                        drive_cycle(($urandom_range(99) < wr_pct) ? 1'b0 : 1'b1,
                                    ($urandom_range(99) < rd_pct) ? 1'b0 : 1'b1,
                                    fifo16_pkg::data_t'($urandom));
                end
                drive_cycle(1'b1, 1'b1, 8'h00);

                // 5. Write and read together while full.
                fill_until_full(40);
                drive_cycle(1'b0, 1'b0, 8'h5a);         // Read taken, write refused.
                drive_cycle(1'b1, 1'b1, 8'h00);
                assert (level === fifo16_pkg::level_t'(fifo16_pkg::depth - 1)
                        && full === 1'b0)
                else
                begin
                        value_errs++;
                        $display("ERR %0t: level %0d full %b after dropped write",
                                 $time, level, full);
                end
                drain_until_empty(24);                  // 8'h5a must not show up.
                repeat (2) drive_cycle(1'b1, 1'b1, 8'h00);

                $display("Summary: %0d value errors, %0d timeouts", value_errs, timeouts);
                if (value_errs == 0 && timeouts == 0)
                        $display("TB PASSED");
                else
                        $display("TB FAILED");
                $finish;
        end

endmodule

// ==== fifo16.f ====
fifo16_pkg.sv
fifo16_mem_if.sv
fifo16_regs.sv
fifo16_wr_ctrl.sv
fifo16_rd_ctrl.sv
fifo16_top.sv
fifo16_asserts.sv
fifo16_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FIFO16 testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=fifo16_sim
LOG=sim.log

# Compile the design, the bound assertions and the testbench.
verilator --binary --timing --assert \
        -f fifo16.f \
        --top-module fifo16_tb \
        --Mdir "$OBJ_DIR" \
        -o "$SIM_BIN"
if [ $? -ne 0 ]; then
        echo "Build with Verilator failed"
        exit 1
fi

# Run the simulation and keep its output.
"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

# The log decides the result.
if grep -qx "TB PASSED" "$LOG"; then
        echo "Result: pass"
        exit 0
else
        echo "Result: fail"
        exit 1
fi
